//--- Bender.yml
package:
  name: csr_unit

dependencies: {}

sources:
  # Package first, then leaf modules and the top level
  - verilog/csr_pkg.sv
  - verilog/csr_counters.sv
  - verilog/csr_stage.sv
  - verilog/csr_top.sv

  # Testbench
  - target: simulation
    files:
      - sim/csr_tb.sv

//--- project.f
verilog/csr_pkg.sv
verilog/csr_counters.sv
verilog/csr_stage.sv
verilog/csr_top.sv
sim/csr_tb.sv

//--- sim/csr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_tb;

    // Run length and limits
    localparam int N_RAND         = 150;
    localparam int N_HAZARD       = 40;
    localparam int N_CMDS         = N_RAND + N_HAZARD + 141;
    localparam int TIMEOUT_CYCLES = 2 * N_CMDS + 200;

    logic                 clk;
    logic                 rst;
    logic                 branch_hazard;
    csr_pkg::csr_req_t    req;
    csr_pkg::csr_cmd_e    cmd_out;
    csr_pkg::xlen_t       rdata;
    csr_pkg::xlen_t       trap_vector;

    // Stimulus LFSR state
    logic [31:0]          lfsr = 32'd24;
    int                   cycles = 0;

    // Shadow model state
    csr_pkg::xlen_t       shadow [0:4095];
    csr_pkg::priv_e       model_mode;
    csr_pkg::counter_t    model_cycle;
    csr_pkg::csr_cmd_e    cur_cmd;
    csr_pkg::csr_addr_t   cur_addr;
    csr_pkg::xlen_t       cur_op;
    csr_pkg::xlen_t       cur_old;
    csr_pkg::csr_cmd_e    p_cmd;
    csr_pkg::csr_addr_t   p_addr;
    csr_pkg::xlen_t       p_op;
    csr_pkg::xlen_t       p_old;
    csr_pkg::xlen_t       st;
    csr_pkg::priv_e       ret_mode;

    // Expected outputs lag the model by one edge
    logic                 chk_valid;
    csr_pkg::xlen_t       exp_rdata;
    csr_pkg::csr_cmd_e    exp_cmd;
    csr_pkg::xlen_t       exp_trap;

    csr_top csr_top_i (
        .clk           (clk),
        .rst           (rst),
        .branch_hazard (branch_hazard),
        .req           (req),
        .cmd_out       (cmd_out),
        .rdata         (rdata),
        .trap_vector   (trap_vector)
    );

    always #10 clk = ~clk;

    task automatic fail_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on first failure");
    endtask

    // One Galois step with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // The nine fully writable registers
    function automatic csr_pkg::csr_addr_t plain_addr(input int idx);
        case (idx)
            0: return csr_pkg::CSR_ADDR_MSCRATCH;
            1: return csr_pkg::CSR_ADDR_MEPC;
            2: return csr_pkg::CSR_ADDR_MTVEC;
            3: return csr_pkg::CSR_ADDR_MCAUSE;
            4: return csr_pkg::CSR_ADDR_MTVAL;
            5: return csr_pkg::CSR_ADDR_MIE;
            6: return csr_pkg::CSR_ADDR_MIP;
            7: return csr_pkg::CSR_ADDR_MEDELEG;
            default: return csr_pkg::CSR_ADDR_MIDELEG;
        endcase
    endfunction

    // Bits that a write may change
    function automatic csr_pkg::xlen_t write_mask(input csr_pkg::csr_addr_t a);
        case (a)
            csr_pkg::CSR_ADDR_MSTATUS:  return csr_pkg::MSTATUS_WMASK;
            csr_pkg::CSR_ADDR_MSTATUSH: return csr_pkg::MSTATUSH_WMASK;
            csr_pkg::CSR_ADDR_MEDELEG, csr_pkg::CSR_ADDR_MIDELEG, csr_pkg::CSR_ADDR_MIE,
            csr_pkg::CSR_ADDR_MTVEC, csr_pkg::CSR_ADDR_MSCRATCH, csr_pkg::CSR_ADDR_MEPC,
            csr_pkg::CSR_ADDR_MCAUSE, csr_pkg::CSR_ADDR_MTVAL, csr_pkg::CSR_ADDR_MIP:
                return '1;
            default: return '0;
        endcase
    endfunction

    // Counter halves come from the edge count and the rest from the shadow
    function automatic csr_pkg::xlen_t model_read(input csr_pkg::csr_addr_t a);
        csr_pkg::counter_t usec;
        usec = model_cycle / csr_pkg::CLK_MHZ;
        case (a)
            csr_pkg::CSR_ADDR_CYCLE:  return model_cycle[31:0];
            csr_pkg::CSR_ADDR_CYCLEH: return model_cycle[63:32];
            csr_pkg::CSR_ADDR_TIME:   return usec[31:0];
            csr_pkg::CSR_ADDR_TIMEH:  return usec[63:32];
            default:                  return shadow[a];
        endcase
    endfunction

    // Drive one command on the next rising edge
    task automatic issue(input csr_pkg::csr_cmd_e cmd, input csr_pkg::csr_addr_t addr,
                         input csr_pkg::xlen_t op, input logic kill);
        csr_pkg::csr_req_t r;
        csr_pkg::xlen_t    upper;
        r.cmd      = cmd;
        r.op1_data = op;
        upper      = rand_bits(20);
        r.imm_i    = {upper[19:0], addr};
        @(posedge clk);
        req           <= r;
        branch_hazard <= kill;
    endtask

    task automatic read_csr(input csr_pkg::csr_addr_t addr);
        issue(csr_pkg::CSR_X, addr, '0, 1'b0);
    endtask

    task automatic idle(input int n);
        repeat (n) read_csr(12'h000);
    endtask

    // Shadow model reads before applying the older command's update
    always @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < 4096; a++) begin
                shadow[a] = '0;
            end
            model_mode  = csr_pkg::PRIV_MACHINE;
            model_cycle = '0;
            p_cmd       = csr_pkg::CSR_X;
            exp_trap    = '0;
            chk_valid   = 1'b0;
        end else begin
            // Killed slot turns into a bubble at address fff
            if (branch_hazard) begin
                cur_cmd  = csr_pkg::CSR_X;
                cur_addr = 12'hfff;
                cur_op   = '1;
            end else begin
                cur_cmd  = req.cmd;
                cur_addr = req.imm_i[11:0];
                cur_op   = req.op1_data;
            end
            cur_old = model_read(cur_addr);

            // Previous command's second stage
            case (p_cmd)
                csr_pkg::CSR_W:
                    shadow[p_addr] = (shadow[p_addr] & ~write_mask(p_addr))
                                     | (p_op & write_mask(p_addr));
                csr_pkg::CSR_S:
                    shadow[p_addr] = (shadow[p_addr] & ~write_mask(p_addr))
                                     | ((p_old | p_op) & write_mask(p_addr));
                csr_pkg::CSR_C:
                    shadow[p_addr] = (shadow[p_addr] & ~write_mask(p_addr))
                                     | ((p_old & ~p_op) & write_mask(p_addr));
                csr_pkg::CSR_ECALL: begin
                    if (model_mode == csr_pkg::PRIV_MACHINE)
                        shadow[csr_pkg::CSR_ADDR_MCAUSE] = 32'd11;
                    else if (model_mode == csr_pkg::PRIV_SUPERVISOR)
                        shadow[csr_pkg::CSR_ADDR_MCAUSE] = 32'd9;
                    else
                        shadow[csr_pkg::CSR_ADDR_MCAUSE] = 32'd8;
                    exp_trap = shadow[csr_pkg::CSR_ADDR_MTVEC];
                end
                csr_pkg::CSR_MRET: begin
                    st = shadow[csr_pkg::CSR_ADDR_MSTATUS];
                    if (st[12:11] == 2'b11)
                        ret_mode = csr_pkg::PRIV_MACHINE;
                    else if (st[12:11] == 2'b01)
                        ret_mode = csr_pkg::PRIV_SUPERVISOR;
                    else
                        ret_mode = csr_pkg::PRIV_USER;
                    // MPP to user, MPIE into MIE, MPRV off below machine
                    st[12:11] = 2'b00;
                    st[3]     = st[7];
                    if (ret_mode != csr_pkg::PRIV_MACHINE)
                        st[17] = 1'b0;
                    shadow[csr_pkg::CSR_ADDR_MSTATUS] = st;
                    model_mode = ret_mode;
                    exp_trap   = shadow[csr_pkg::CSR_ADDR_MEPC];
                end
                default: ;
            endcase

            exp_rdata   = cur_old;
            exp_cmd     = cur_cmd;
            p_cmd       = cur_cmd;
            p_addr      = cur_addr;
            p_op        = cur_op;
            p_old       = cur_old;
            model_cycle = model_cycle + 64'd1;
            chk_valid   = 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) chk_valid |-> rdata == exp_rdata)
        else begin
            $display("mismatch rdata: got %h expected %h",
                     $sampled(rdata), $sampled(exp_rdata));
            fail_run();
        end

    assert property (@(posedge clk) disable iff (rst) chk_valid |-> cmd_out == exp_cmd)
        else begin
            $display("mismatch cmd_out: got %h expected %h",
                     $sampled(cmd_out), $sampled(exp_cmd));
            fail_run();
        end

    // Trap vector holds its value between traps
    assert property (@(posedge clk) disable iff (rst) chk_valid |-> trap_vector == exp_trap)
        else begin
            $display("mismatch trap_vector: got %h expected %h",
                     $sampled(trap_vector), $sampled(exp_trap));
            fail_run();
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_run();
        end
    end

    initial begin
        csr_pkg::csr_cmd_e  c;
        csr_pkg::csr_addr_t a;
        csr_pkg::xlen_t     v;
        logic               k;
        clk           = 1'b0;
        rst           = 1'b1;
        branch_hazard = 1'b0;
        req           = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Back-to-back reads, writes, sets and clears
        for (int n = 0; n < N_RAND; n++) begin
            c = csr_pkg::csr_cmd_e'(3'(rand_bits(2)));
            a = plain_addr(int'(rand_bits(4) % 9));
            v = rand_bits(32);
            issue(c, a, v, 1'b0);
        end

        // Masked status registers
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_MSTATUS, rand_bits(32), 1'b0);
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_MSTATUSH, rand_bits(32), 1'b0);
        idle(2);
        issue(csr_pkg::CSR_S, csr_pkg::CSR_ADDR_MSTATUS, rand_bits(32), 1'b0);
        issue(csr_pkg::CSR_S, csr_pkg::CSR_ADDR_MSTATUSH, rand_bits(32), 1'b0);
        idle(2);
        read_csr(csr_pkg::CSR_ADDR_MSTATUS);
        read_csr(csr_pkg::CSR_ADDR_MSTATUSH);

        // Counters, mvendorid and an unknown address ignore writes
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_CYCLE, rand_bits(32), 1'b0);
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_TIME, rand_bits(32), 1'b0);
        issue(csr_pkg::CSR_W, 12'hf11, rand_bits(32), 1'b0);
        issue(csr_pkg::CSR_W, 12'h7c5, rand_bits(32), 1'b0);
        idle(2);
        read_csr(12'hf11);
        read_csr(12'h7c5);
        read_csr(12'h301);
        read_csr(12'h34a);
        read_csr(12'h34b);

        // Cycle and microsecond counts
        read_csr(csr_pkg::CSR_ADDR_CYCLE);
        read_csr(csr_pkg::CSR_ADDR_CYCLEH);
        idle(3 * csr_pkg::CLK_MHZ);
        read_csr(csr_pkg::CSR_ADDR_TIME);
        read_csr(csr_pkg::CSR_ADDR_TIMEH);
        read_csr(csr_pkg::CSR_ADDR_CYCLE);

        // Machine-mode ecall
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_MTVEC, rand_bits(32), 1'b0);
        idle(2);
        issue(csr_pkg::CSR_ECALL, 12'h000, '0, 1'b0);
        idle(2);
        read_csr(csr_pkg::CSR_ADDR_MCAUSE);

        // Random kills mixed with live commands
        for (int n = 0; n < N_HAZARD; n++) begin
            k = 1'(rand_bits(1));
            if (k) begin
                c = csr_pkg::csr_cmd_e'(3'(rand_bits(3) % 6));
                a = 12'(rand_bits(12));
            end else begin
                c = csr_pkg::csr_cmd_e'(3'(rand_bits(2)));
                a = plain_addr(int'(rand_bits(4) % 9));
            end
            v = rand_bits(32);
            issue(c, a, v, k);
        end
        idle(2);
        for (int n = 0; n < 9; n++) begin
            read_csr(plain_addr(n));
        end

        // mret into user mode and then an ecall from user
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_MEPC, rand_bits(32), 1'b0);
        issue(csr_pkg::CSR_W, csr_pkg::CSR_ADDR_MSTATUS, 32'h0002_0080, 1'b0);
        idle(2);
        issue(csr_pkg::CSR_MRET, 12'h000, '0, 1'b0);
        idle(2);
        read_csr(csr_pkg::CSR_ADDR_MSTATUS);
        issue(csr_pkg::CSR_ECALL, 12'h000, '0, 1'b0);
        idle(2);
        read_csr(csr_pkg::CSR_ADDR_MCAUSE);

        // Drain the pipeline through the last checks
        idle(4);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/csr_counters.sv
`timescale 1ns/1ps
`default_nettype none

module csr_counters (
    input  wire                  clk,
    input  wire                  rst,
    output csr_pkg::csr_counts_t counts
);

    // Edge count within the current microsecond
    logic [csr_pkg::PRESCALE_W-1:0] prescale;

    // Cycle counter, one step per edge after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            counts.cycle <= '0;
        end else begin
            counts.cycle <= counts.cycle + 64'd1;
        end
    end

    // Prescaler wraps every CLK_MHZ edges
    always_ff @(posedge clk) begin
        if (rst) begin
            prescale <= '0;
        end else if (prescale == csr_pkg::PRESCALE_LAST) begin
            prescale <= '0;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    // Microsecond tick on prescaler wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            counts.time_us <= '0;
        end else if (prescale == csr_pkg::PRESCALE_LAST) begin
            counts.time_us <= counts.time_us + 64'd1;
        end
    end

    // Prescaler width exceeds the count range, must stay in it
    assert property (@(posedge clk) disable iff (rst)
        prescale <= csr_pkg::PRESCALE_LAST);

endmodule

`default_nettype wire

//--- verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // Data word, CSR address and counter widths
    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [63:0] counter_t;

    // Command codes arriving from decode
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_e;

    // Privilege modes, encoding 2 is reserved
    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE    = 2'd3
    } priv_e;

    // One command per cycle from the pipeline
    typedef struct packed {
        csr_cmd_e cmd;
        xlen_t    op1_data;
        xlen_t    imm_i;
    } csr_req_t;

    // Free-running counters seen by the read mux
    typedef struct packed {
        counter_t cycle;
        counter_t time_us;
    } csr_counts_t;

    // Core clock in MHz, drives the microsecond prescaler
    localparam int CLK_MHZ = 27;
    localparam int PRESCALE_W = $clog2(CLK_MHZ);
    localparam logic [PRESCALE_W-1:0] PRESCALE_LAST = PRESCALE_W'(CLK_MHZ - 1);

    // Counters and timers, user read-only
    localparam csr_addr_t CSR_ADDR_CYCLE    = 12'hc00;
    localparam csr_addr_t CSR_ADDR_TIME     = 12'hc01;
    localparam csr_addr_t CSR_ADDR_CYCLEH   = 12'hc80;
    localparam csr_addr_t CSR_ADDR_TIMEH    = 12'hc81;

    // Machine trap setup
    localparam csr_addr_t CSR_ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_ADDR_MEDELEG  = 12'h302;
    localparam csr_addr_t CSR_ADDR_MIDELEG  = 12'h303;
    localparam csr_addr_t CSR_ADDR_MIE      = 12'h304;
    localparam csr_addr_t CSR_ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_ADDR_MSTATUSH = 12'h310;

    // Machine trap handling
    localparam csr_addr_t CSR_ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_ADDR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_ADDR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_ADDR_MIP      = 12'h344;

    // Writable mstatus bits: SD, TSR..SPIE, MIE, SIE
    localparam xlen_t MSTATUS_WMASK  = 32'h807f_ffea;
    // MBE and SBE only
    localparam xlen_t MSTATUSH_WMASK = 32'h0000_0030;

    // mstatus field positions touched by mret
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;
    localparam int MSTATUS_MPRV   = 17;

    // Environment call causes per originating mode
    localparam xlen_t CAUSE_ECALL_U = 32'd8;
    localparam xlen_t CAUSE_ECALL_S = 32'd9;
    localparam xlen_t CAUSE_ECALL_M = 32'd11;

endpackage

`default_nettype wire

//--- verilog/csr_stage.sv
`timescale 1ns/1ps
`default_nettype none

module csr_stage (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   branch_hazard,
    input  wire csr_pkg::csr_req_t    req,
    input  wire csr_pkg::csr_counts_t counts,
    output csr_pkg::csr_cmd_e     cmd_out,
    output csr_pkg::xlen_t        rdata,
    output csr_pkg::xlen_t        trap_vector
);

    // Stage one view after the hazard kill
    csr_pkg::csr_cmd_e  cmd;
    csr_pkg::xlen_t     op1_data;
    csr_pkg::xlen_t     imm_i;
    csr_pkg::csr_addr_t addr;
    csr_pkg::xlen_t     rd_value;

    // Saved for the second stage, cmd_out doubles as the saved command
    csr_pkg::csr_addr_t save_addr;
    csr_pkg::xlen_t     save_op1;

    // Second stage write data
    csr_pkg::xlen_t     wdata;

    // Current privilege mode
    csr_pkg::priv_e     mode;
    csr_pkg::priv_e     mret_mode;
    logic [1:0]         mpp;

    // Implemented machine CSRs
    csr_pkg::xlen_t     mstatus;
    csr_pkg::xlen_t     mstatush;
    csr_pkg::xlen_t     medeleg;
    csr_pkg::xlen_t     mideleg;
    csr_pkg::xlen_t     mie;
    csr_pkg::xlen_t     mtvec;
    csr_pkg::xlen_t     mscratch;
    csr_pkg::xlen_t     mepc;
    csr_pkg::xlen_t     mcause;
    csr_pkg::xlen_t     mtval;
    csr_pkg::xlen_t     mip;

    // Branch hazard in writeback turns the slot into a bubble
    always_comb begin
        if (branch_hazard) begin
            cmd      = csr_pkg::CSR_X;
            op1_data = '1;
            imm_i    = '1;
        end else begin
            cmd      = req.cmd;
            op1_data = req.op1_data;
            imm_i    = req.imm_i;
        end
    end

    // CSR address sits in the low immediate bits
    assign addr = imm_i[11:0];

    // Read mux over all implemented registers
    always_comb begin
        case (addr)
            csr_pkg::CSR_ADDR_CYCLE:    rd_value = counts.cycle[31:0];
            csr_pkg::CSR_ADDR_TIME:     rd_value = counts.time_us[31:0];
            csr_pkg::CSR_ADDR_CYCLEH:   rd_value = counts.cycle[63:32];
            csr_pkg::CSR_ADDR_TIMEH:    rd_value = counts.time_us[63:32];
            csr_pkg::CSR_ADDR_MSTATUS:  rd_value = mstatus;
            csr_pkg::CSR_ADDR_MEDELEG:  rd_value = medeleg;
            csr_pkg::CSR_ADDR_MIDELEG:  rd_value = mideleg;
            csr_pkg::CSR_ADDR_MIE:      rd_value = mie;
            csr_pkg::CSR_ADDR_MTVEC:    rd_value = mtvec;
            csr_pkg::CSR_ADDR_MSTATUSH: rd_value = mstatush;
            csr_pkg::CSR_ADDR_MSCRATCH: rd_value = mscratch;
            csr_pkg::CSR_ADDR_MEPC:     rd_value = mepc;
            csr_pkg::CSR_ADDR_MCAUSE:   rd_value = mcause;
            csr_pkg::CSR_ADDR_MTVAL:    rd_value = mtval;
            csr_pkg::CSR_ADDR_MIP:      rd_value = mip;
            // misa, mtinst, mtval2, info regs and unknowns
            default:                    rd_value = '0;
        endcase
    end

    // Stage one registers
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_out <= csr_pkg::CSR_X;
            rdata   <= '0;
        end else begin
            cmd_out <= cmd;
            rdata   <= rd_value;
        end
    end

    // Address and operand ride along into stage two
    always_ff @(posedge clk) begin
        save_addr <= addr;
        save_op1  <= op1_data;
    end

    // Read-modify-write against the old value in rdata
    always_comb begin
        case (cmd_out)
            csr_pkg::CSR_W: wdata = save_op1;
            csr_pkg::CSR_S: wdata = rdata | save_op1;
            csr_pkg::CSR_C: wdata = rdata & ~save_op1;
            default:        wdata = '0;
        endcase
    end

    // Return mode from MPP
    assign mpp = mstatus[csr_pkg::MSTATUS_MPP_LO +: 2];

    // Reserved MPP encoding lands in user mode
    always_comb begin
        case (mpp)
            2'd3:    mret_mode = csr_pkg::PRIV_MACHINE;
            2'd1:    mret_mode = csr_pkg::PRIV_SUPERVISOR;
            default: mret_mode = csr_pkg::PRIV_USER;
        endcase
    end

    // Stage two: register update, ecall and mret
    always_ff @(posedge clk) begin
        if (rst) begin
            mode        <= csr_pkg::PRIV_MACHINE;
            trap_vector <= '0;
            mstatus     <= '0;
            mstatush    <= '0;
            medeleg     <= '0;
            mideleg     <= '0;
            mie         <= '0;
            mtvec       <= '0;
            mscratch    <= '0;
            mepc        <= '0;
            mcause      <= '0;
            mtval       <= '0;
            mip         <= '0;
        end else begin
            case (cmd_out)
                csr_pkg::CSR_ECALL: begin
                    // Cause depends on the mode that called
                    case (mode)
                        csr_pkg::PRIV_MACHINE:    mcause <= csr_pkg::CAUSE_ECALL_M;
                        csr_pkg::PRIV_SUPERVISOR: mcause <= csr_pkg::CAUSE_ECALL_S;
                        default:                  mcause <= csr_pkg::CAUSE_ECALL_U;
                    endcase
                    trap_vector <= mtvec;
                end
                csr_pkg::CSR_MRET: begin
                    mode <= mret_mode;
                    // MPP drops to the lowest supported mode
                    mstatus[csr_pkg::MSTATUS_MPP_LO +: 2] <= 2'(csr_pkg::PRIV_USER);
                    mstatus[csr_pkg::MSTATUS_MIE] <= mstatus[csr_pkg::MSTATUS_MPIE];
                    // MPRV only survives a return into machine mode
                    if (mret_mode != csr_pkg::PRIV_MACHINE) begin
                        mstatus[csr_pkg::MSTATUS_MPRV] <= 1'b0;
                    end
                    trap_vector <= mepc;
                end
                csr_pkg::CSR_W, csr_pkg::CSR_S, csr_pkg::CSR_C: begin
                    case (save_addr)
                        // Only the implemented status fields
                        csr_pkg::CSR_ADDR_MSTATUS:
                            mstatus <= wdata & csr_pkg::MSTATUS_WMASK;
                        csr_pkg::CSR_ADDR_MSTATUSH:
                            mstatush <= wdata & csr_pkg::MSTATUSH_WMASK;
                        csr_pkg::CSR_ADDR_MEDELEG:  medeleg  <= wdata;
                        csr_pkg::CSR_ADDR_MIDELEG:  mideleg  <= wdata;
                        csr_pkg::CSR_ADDR_MIE:      mie      <= wdata;
                        csr_pkg::CSR_ADDR_MTVEC:    mtvec    <= wdata;
                        csr_pkg::CSR_ADDR_MSCRATCH: mscratch <= wdata;
                        csr_pkg::CSR_ADDR_MEPC:     mepc     <= wdata;
                        csr_pkg::CSR_ADDR_MCAUSE:   mcause   <= wdata;
                        csr_pkg::CSR_ADDR_MTVAL:    mtval    <= wdata;
                        csr_pkg::CSR_ADDR_MIP:      mip      <= wdata;
                        // Counters and zero-reading addresses
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    // Killed slot leaves stage one as a bubble reading zero
    assert property (@(posedge clk) disable iff (rst)
        branch_hazard |=> (cmd_out == csr_pkg::CSR_X) && (rdata == '0));

    // Reserved privilege encoding never reached
    assert property (@(posedge clk) disable iff (rst)
        2'(mode) != 2'b10);

    // Trap vector only moves right after ecall or mret in stage two
    assert property (@(posedge clk) disable iff (rst)
        (!$past(rst) && (trap_vector != $past(trap_vector)))
            |-> ($past(cmd_out) inside {csr_pkg::CSR_ECALL, csr_pkg::CSR_MRET}));

endmodule

`default_nettype wire

//--- verilog/csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    branch_hazard,
    input  wire csr_pkg::csr_req_t req,
    output csr_pkg::csr_cmd_e      cmd_out,
    output csr_pkg::xlen_t         rdata,
    output csr_pkg::xlen_t         trap_vector
);

    // Cycle and microsecond counts into the read mux
    csr_pkg::csr_counts_t counts;

    // Free-running counters
    csr_counters csr_counters_i (
        .clk    (clk),
        .rst    (rst),
        .counts (counts)
    );

    // Two-deep CSR pipeline
    csr_stage csr_stage_i (
        .clk           (clk),
        .rst           (rst),
        .branch_hazard (branch_hazard),
        .req           (req),
        .counts        (counts),
        .cmd_out       (cmd_out),
        .rdata         (rdata),
        .trap_vector   (trap_vector)
    );

endmodule

`default_nettype wire
